/* dbp.f */
src/bp_pkg.sv
src/pred_table.sv
src/bp_ctrl.sv
src/redirect_unit.sv
src/dyn_branch_predictor.sv
tests/tb_dbp.sv

/* src/bp_ctrl.sv */
// Control for the dynamic branch predictor
// Fetch index extraction and enable gating of the lookup outputs
// Lookup register holding PC, counter and target for resolution
// Training write enables and saturating counter next state

`timescale 1ns/1ps

module bp_ctrl (
  input  logic          clk,
  input  logic          rst,                          // Sync, active high
  input  logic          enable,                       // Predictor active this cycle

  // Fetch side
  input  bp_pkg::pc_t   pc_curr,                      // PC being fetched
  input  bp_pkg::ctr_t  bht_rd,                       // BHT entry at rd_idx
  input  bp_pkg::pc_t   btb_rd,                       // BTB entry at rd_idx

  // Decode side, about the registered lookup
  input  logic          was_branch,                   // Resolved instr is a branch
  input  logic          actual_taken,                 // Resolved direction
  input  bp_pkg::pc_t   actual_target,                // Resolved target

  // Table read index
  output bp_pkg::idx_t  rd_idx,

  // Prediction to fetch
  output bp_pkg::ctr_t  prediction,                   // Zero when disabled
  output bp_pkg::pc_t   predicted_target,             // Zero when disabled

  // Registered lookup
  output logic          lu_valid,                     // Lookup awaiting resolution
  output bp_pkg::pc_t   lu_pc,
  output bp_pkg::ctr_t  lu_ctr,
  output bp_pkg::pc_t   lu_target,

  // Table write side
  output logic          bht_we,
  output logic          btb_we,
  output bp_pkg::idx_t  wr_idx,                       // Shared by BHT and BTB
  output bp_pkg::ctr_t  bht_wdata                     // Next counter state
);

  import bp_pkg::*;

  logic train;                                         // Resolved branch this cycle
  ctr_t ctr_next;                                      // Counter after this outcome

  ////////////////////////////////////////////////////////////
  // Lookup path
  ////////////////////////////////////////////////////////////
  // Halfword instructions, so PC bit 0 is never part of the index
  assign rd_idx = pc_curr[IDX_LSB +: IDX_W];

  // Outputs forced to zero while the predictor is idle
  assign prediction       = enable ? bht_rd : strong_nt;
  assign predicted_target = enable ? btb_rd : PC_RESET;

  ////////////////////////////////////////////////////////////
  // Lookup register
  ////////////////////////////////////////////////////////////
  // Valid flag follows enable with one cycle of delay
  always_ff @(posedge clk) begin
    if (rst) begin
      lu_valid <= 1'b0;
    end else begin
      lu_valid <= enable;                              // Cleared by an idle cycle
    end
  end

  // Payload captured on every active lookup
  // Raw table reads are kept, matching what fetch was given
  always_ff @(posedge clk) begin
    if (enable) begin
      lu_pc     <= pc_curr;                            // For index and fall-through
      lu_ctr    <= bht_rd;                             // Direction used at fetch
      lu_target <= btb_rd;                             // Target used at fetch
    end
  end

  ////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////
  // Only branches train, and only against a live lookup
  assign train = lu_valid & was_branch;

  assign bht_we = train;                               // Counter moves on every branch
  assign btb_we = train & actual_taken;                // Target only learned when taken

  // Write goes back to the entry the lookup read from
  assign wr_idx = lu_pc[IDX_LSB +: IDX_W];

  // Saturating 2-bit counter
  // Taken steps toward strong_t, not taken toward strong_nt
  always_comb begin
    ctr_next = lu_ctr;                                 // Hold by default
    case (lu_ctr)
      strong_nt: begin
        ctr_next = actual_taken ? weak_nt : strong_nt; // Saturate low
      end
      weak_nt: begin
        ctr_next = actual_taken ? weak_t : strong_nt;
      end
      weak_t: begin
        ctr_next = actual_taken ? strong_t : weak_nt;
      end
      strong_t: begin
        ctr_next = actual_taken ? strong_t : weak_t;   // Saturate high
      end
      default: begin
        ctr_next = CTR_RESET;
      end
    endcase
  end

  assign bht_wdata = ctr_next;

  // BTB write data is actual_target, wired straight from decode at the top

endmodule

/* src/bp_pkg.sv */
// Shared definitions for the dynamic branch predictor
// Widths, table geometry, PC and index types
// 2-bit saturating counter encoding and table reset values

package bp_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////
  localparam int unsigned PC_W        = 16;            // Instruction address width
  localparam int unsigned IDX_W       = 3;             // Table index width
  localparam int unsigned IDX_LSB     = 1;             // Halfword aligned, skip bit 0
  localparam int unsigned TABLE_DEPTH = 1 << IDX_W;    // 8 entries
  localparam int unsigned INSTR_BYTES = 2;             // Fall-through increment

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////
  typedef logic [PC_W-1:0]  pc_t;                      // PC or branch target
  typedef logic [IDX_W-1:0] idx_t;                     // BHT / BTB index

  // 2-bit saturating direction counter
  // Upper bit set means predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_t;

  ////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////
  localparam ctr_t CTR_RESET = strong_nt;              // Cold BHT predicts not taken
  localparam pc_t  PC_RESET  = '0;                     // Cold BTB target

endpackage

/* src/dyn_branch_predictor.sv */
// Dynamic branch predictor top level
// BHT and BTB tables, lookup and training control, redirect unit
// Lookup in the fetch cycle, resolution and training one cycle later

`timescale 1ns/1ps

module dyn_branch_predictor (
  input  logic         clk,
  input  logic         rst,                           // Sync, active high
  input  logic         enable,                        // Predictor active

  // Fetch
  input  bp_pkg::pc_t  pc_curr,                       // PC being fetched

  // Decode resolution of the previous lookup
  input  logic         was_branch,
  input  logic         actual_taken,
  input  bp_pkg::pc_t  actual_target,

  // Prediction to fetch
  output bp_pkg::ctr_t prediction,
  output bp_pkg::pc_t  predicted_target,

  // Redirect to fetch
  output logic         mispredict,
  output bp_pkg::pc_t  redirect_pc
);

  import bp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////
  idx_t rd_idx;                                        // Fetch index into both tables
  ctr_t bht_rd;
  pc_t  btb_rd;

  logic lu_valid;                                      // Registered lookup
  pc_t  lu_pc;
  ctr_t lu_ctr;
  pc_t  lu_target;

  logic bht_we;                                        // Training writes
  logic btb_we;
  idx_t wr_idx;
  ctr_t bht_wdata;

  ////////////////////////////////////////////////////////////
  // Tables
  ////////////////////////////////////////////////////////////
  // Branch history table, direction counters
  pred_table #(
    .entry_t   (ctr_t),
    .RESET_VAL (CTR_RESET)
  ) i_bht (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_data (bht_rd),
    .wr_en   (bht_we),
    .wr_idx  (wr_idx),
    .wr_data (bht_wdata)
  );

  // Branch target buffer, last taken target per index
  pred_table #(
    .entry_t   (pc_t),
    .RESET_VAL (PC_RESET)
  ) i_btb (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_data (btb_rd),
    .wr_en   (btb_we),
    .wr_idx  (wr_idx),
    .wr_data (actual_target)                           // Straight from decode
  );

  ////////////////////////////////////////////////////////////
  // Control and redirect
  ////////////////////////////////////////////////////////////
  bp_ctrl i_ctrl (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc_curr          (pc_curr),
    .bht_rd           (bht_rd),
    .btb_rd           (btb_rd),
    .was_branch       (was_branch),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .rd_idx           (rd_idx),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .lu_valid         (lu_valid),
    .lu_pc            (lu_pc),
    .lu_ctr           (lu_ctr),
    .lu_target        (lu_target),
    .bht_we           (bht_we),
    .btb_we           (btb_we),
    .wr_idx           (wr_idx),
    .bht_wdata        (bht_wdata)
  );

  redirect_unit i_redirect (
    .lu_valid      (lu_valid),
    .lu_pc         (lu_pc),
    .lu_ctr        (lu_ctr),
    .lu_target     (lu_target),
    .was_branch    (was_branch),
    .actual_taken  (actual_taken),
    .actual_target (actual_target),
    .mispredict    (mispredict),
    .redirect_pc   (redirect_pc)
  );

endmodule

/* src/pred_table.sv */
// Indexed prediction table, payload chosen by a type parameter
// Asynchronous read port, one synchronous write port
// All entries return to RESET_VAL on reset
// Used as the BHT (ctr_t) and as the BTB (pc_t)

`timescale 1ns/1ps

module pred_table #(
  parameter type    entry_t   = logic [1:0],           // Payload type of one entry
  parameter entry_t RESET_VAL = entry_t'(0)            // Value of every entry after reset
) (
  input  logic         clk,
  input  logic         rst,                           // Sync, active high

  // Read port, fetch side
  input  bp_pkg::idx_t rd_idx,                        // Index from current PC
  output entry_t       rd_data,                       // Entry at rd_idx, same cycle

  // Write port, training side
  input  logic         wr_en,                         // Commit wr_data at next edge
  input  bp_pkg::idx_t wr_idx,                        // Index of resolved lookup
  input  entry_t       wr_data                        // New entry value
);

  import bp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  entry_t mem [TABLE_DEPTH];                           // One entry per index

  // Write port
  // A write lands at the edge, so a read of the same entry
  // in the write cycle still sees the old contents
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TABLE_DEPTH; i++) begin
        mem[i] <= RESET_VAL;                           // Clear whole table
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;                          // Single entry update
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////
  // Combinational lookup, no bypass from the write port
  assign rd_data = mem[rd_idx];

endmodule

/* src/redirect_unit.sv */
// Misprediction detection for the registered lookup
// Direction compare, taken-target compare and non-branch case
// Redirect PC select between resolved target and fall-through

`timescale 1ns/1ps

module redirect_unit (
  // Registered lookup
  input  logic         lu_valid,                      // Lookup awaiting resolution
  input  bp_pkg::pc_t  lu_pc,                         // PC of that lookup
  input  bp_pkg::ctr_t lu_ctr,                        // Counter given to fetch
  input  bp_pkg::pc_t  lu_target,                     // Target given to fetch

  // Resolution from decode
  input  logic         was_branch,
  input  logic         actual_taken,
  input  bp_pkg::pc_t  actual_target,

  // Front-end redirect
  output logic         mispredict,                    // Fetch went the wrong way
  output bp_pkg::pc_t  redirect_pc                    // Correct next PC, zero otherwise
);

  import bp_pkg::*;

  logic pred_taken;                                    // Direction fetch followed
  logic dir_wrong;                                     // Direction mismatch
  logic tgt_wrong;                                     // Taken, but wrong address
  logic branch_miss;
  pc_t  fall_through;                                  // Next sequential PC
  pc_t  correct_pc;                                    // Where fetch should have gone

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////
  // Upper half of the counter range predicts taken
  assign pred_taken = (lu_ctr == weak_t) || (lu_ctr == strong_t);

  assign dir_wrong   = pred_taken ^ actual_taken;
  assign tgt_wrong   = actual_taken && (lu_target != actual_target);
  assign branch_miss = dir_wrong | tgt_wrong;

  // Non-branch costs a redirect only if fetch jumped away
  always_comb begin
    mispredict = 1'b0;
    if (lu_valid) begin
      mispredict = was_branch ? branch_miss : pred_taken;
    end
  end

  ////////////////////////////////////////////////////////////
  // Redirect address
  ////////////////////////////////////////////////////////////
  assign fall_through = lu_pc + pc_t'(INSTR_BYTES);   // Wraps at the top of memory

  // Taken branch resumes at its target, anything else falls through
  assign correct_pc = (was_branch && actual_taken) ? actual_target : fall_through;

  assign redirect_pc = mispredict ? correct_pc : PC_RESET;

endmodule

/* tests/tb_dbp.sv */
// Directed testbench for the dynamic branch predictor
// Reference BHT/BTB model with a registered lookup, typed compare tasks
// Tests: reset state, counter walk, BTB training, redirect, random stream

`timescale 1ns/1ps

module tb_dbp;

  import bp_pkg::*;

  localparam int  CLK_PERIOD = 40;
  localparam int  RST_CYCLES = 16;
  localparam time SETTLE     = 5;                      // Sample point after falling edge
  localparam int  N_RAND     = 200;

  // Cycles used by each part of the run
  localparam int LEN_RESET  = RST_CYCLES + 1;
  localparam int LEN_T1     = 14;
  localparam int LEN_T2     = 22;
  localparam int LEN_T3     = 6;
  localparam int LEN_T4     = 12;
  localparam int LEN_T5     = N_RAND + 1;
  localparam int TEST_CYCLES    = LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic clk;
  logic rst;
  logic enable;
  pc_t  pc_curr;
  logic was_branch;
  logic actual_taken;
  pc_t  actual_target;
  ctr_t prediction;
  pc_t  predicted_target;
  logic mispredict;
  pc_t  redirect_pc;

  int     n_errors  = 0;
  int     n_checks  = 0;
  int     cycle_cnt = 0;
  integer seed      = 59379;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  ctr_t ref_ctr [TABLE_DEPTH];                         // Expected BHT
  pc_t  ref_tgt [TABLE_DEPTH];                         // Expected BTB
  logic m_lu_valid;                                    // Expected lookup register
  pc_t  m_lu_pc;
  ctr_t m_lu_ctr;
  pc_t  m_lu_tgt;

  dyn_branch_predictor i_dut (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc_curr          (pc_curr),
    .was_branch       (was_branch),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .mispredict       (mispredict),
    .redirect_pc      (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;    // Run length watchdog

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_ctr(input string what, input ctr_t got, input ctr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input string what, input pc_t got, input pc_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got 0x%04h expected 0x%04h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Index is PC bits [3:1]
  function automatic idx_t idx_of(input pc_t pc);
    return idx_t'(pc[3:1]);
  endfunction

  function automatic logic predicts_taken(input ctr_t c);
    return (c == weak_t) || (c == strong_t);
  endfunction

  // One saturating step toward the outcome
  function automatic ctr_t next_ctr(input ctr_t c, input logic taken);
    if (taken) begin
      return (c == strong_t) ? strong_t : ctr_t'(c + 1);
    end
    return (c == strong_nt) ? strong_nt : ctr_t'(c - 1);
  endfunction

  task automatic reset_model;
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      ref_ctr[i] = strong_nt;
      ref_tgt[i] = '0;
    end
    m_lu_valid = 1'b0;
    m_lu_pc    = '0;
    m_lu_ctr   = strong_nt;
    m_lu_tgt   = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // One clock of lookup plus resolution, checked against the model
  ////////////////////////////////////////////////////////////
  task automatic run_cycle(input logic en, input pc_t pc, input logic wb,
                           input logic taken, input pc_t tgt);
    idx_t idx;
    ctr_t rd_ctr;
    pc_t  rd_tgt;
    logic exp_mis;
    pc_t  exp_redir;
    @(negedge clk);
    enable        = en;
    pc_curr       = pc;
    was_branch    = wb;
    actual_taken  = taken;
    actual_target = tgt;
    #(SETTLE);
    idx    = idx_of(pc);
    rd_ctr = ref_ctr[idx];                             // Old value, write not yet landed
    rd_tgt = ref_tgt[idx];
    exp_mis   = 1'b0;
    exp_redir = '0;
    if (m_lu_valid) begin
      if (wb) begin
        exp_mis = (predicts_taken(m_lu_ctr) != taken) || (taken && (m_lu_tgt != tgt));
      end else begin
        exp_mis = predicts_taken(m_lu_ctr);            // Fetch jumped on a non-branch
      end
    end
    if (exp_mis) begin
      exp_redir = (wb && taken) ? tgt : pc_t'(m_lu_pc + INSTR_BYTES);
    end
    check_ctr("prediction", prediction, en ? rd_ctr : strong_nt);
    check_pc("predicted_target", predicted_target, en ? rd_tgt : pc_t'(0));
    check_bit("mispredict", mispredict, exp_mis);
    check_pc("redirect_pc", redirect_pc, exp_redir);
    // Model of the coming edge: train on old lookup, then capture new one
    if (m_lu_valid && wb) begin
      ref_ctr[idx_of(m_lu_pc)] = next_ctr(m_lu_ctr, taken);
      if (taken) ref_tgt[idx_of(m_lu_pc)] = tgt;
    end
    m_lu_valid = en;
    if (en) begin
      m_lu_pc  = pc;
      m_lu_ctr = rd_ctr;
      m_lu_tgt = rd_tgt;
    end
  endtask

  // Lookup, then resolve it in an idle cycle so nothing overlaps
  task automatic lookup_resolve(input pc_t pc, input logic wb, input logic taken,
                                input pc_t tgt);
    run_cycle(1'b1, pc, 1'b0, 1'b0, '0);
    run_cycle(1'b0, pc, wb, taken, tgt);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_state;
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      run_cycle(1'b1, pc_t'(16'h0100 + 2 * i), 1'b0, 1'b0, '0);
      check_ctr("reset counter", prediction, strong_nt);
      check_pc("reset target", predicted_target, '0);
    end
    run_cycle(1'b0, 16'h0100, 1'b0, 1'b0, '0);        // Last lookup resolves here
    check_ctr("idle prediction", prediction, strong_nt);
    check_pc("idle target", predicted_target, '0);
    repeat (3) begin
      run_cycle(1'b0, 16'h010E, 1'b1, 1'b1, 16'h1234); // No live lookup, no training
      check_bit("idle mispredict", mispredict, 1'b0);
    end
    run_cycle(1'b1, 16'h010E, 1'b0, 1'b0, '0);
    check_ctr("untrained counter", prediction, strong_nt);
    check_pc("untrained target", predicted_target, '0);
    run_cycle(1'b0, 16'h010E, 1'b0, 1'b0, '0);
  endtask

  task automatic walk_step(input logic taken, input ctr_t exp_before);
    run_cycle(1'b1, 16'h012A, 1'b0, 1'b0, '0);
    check_ctr("walk counter", prediction, exp_before);
    run_cycle(1'b0, 16'h012A, 1'b1, taken, 16'h0300);
  endtask

  task automatic test_counter_walk;
    walk_step(1'b1, strong_nt);                        // Up the ladder
    walk_step(1'b1, weak_nt);
    walk_step(1'b1, weak_t);
    walk_step(1'b1, strong_t);
    walk_step(1'b1, strong_t);                         // Saturated high
    walk_step(1'b0, strong_t);                         // And back down
    walk_step(1'b0, weak_t);
    walk_step(1'b0, weak_nt);
    walk_step(1'b0, strong_nt);
    walk_step(1'b0, strong_nt);
    run_cycle(1'b1, 16'h012A, 1'b0, 1'b0, '0);
    check_ctr("walk end", prediction, strong_nt);
    run_cycle(1'b0, 16'h012A, 1'b0, 1'b0, '0);
  endtask

  task automatic test_btb_training;
    lookup_resolve(16'h0206, 1'b1, 1'b1, 16'h0A00);    // Learn target
    run_cycle(1'b1, 16'h0206, 1'b0, 1'b0, '0);
    check_pc("learned target", predicted_target, 16'h0A00);
    run_cycle(1'b0, 16'h0206, 1'b1, 1'b0, 16'h0B00);   // Not taken keeps target
    run_cycle(1'b1, 16'h0216, 1'b0, 1'b0, '0);         // Bit 4 alias, same entry
    check_pc("aliased target", predicted_target, 16'h0A00);
    run_cycle(1'b0, 16'h0206, 1'b0, 1'b0, '0);
  endtask

  task automatic test_mispredict;
    lookup_resolve(16'h008C, 1'b1, 1'b1, 16'h0400);    // Predicted not taken
    check_bit("dir miss", mispredict, 1'b1);
    check_pc("dir miss redirect", redirect_pc, 16'h0400);
    lookup_resolve(16'h008C, 1'b1, 1'b1, 16'h0400);    // Still weak_nt
    check_bit("dir miss 2", mispredict, 1'b1);
    lookup_resolve(16'h008C, 1'b1, 1'b1, 16'h0400);    // Now correct
    check_bit("correct", mispredict, 1'b0);
    check_pc("correct redirect", redirect_pc, '0);
    lookup_resolve(16'h008C, 1'b1, 1'b1, 16'h0480);    // Right way, wrong target
    check_bit("target miss", mispredict, 1'b1);
    check_pc("target miss redirect", redirect_pc, 16'h0480);
    lookup_resolve(16'h008C, 1'b0, 1'b0, '0);          // Non-branch predicted taken
    check_bit("non-branch miss", mispredict, 1'b1);
    check_pc("non-branch redirect", redirect_pc, 16'h008E);
    lookup_resolve(16'h008C, 1'b1, 1'b0, 16'h0480);    // Predicted taken, fell through
    check_bit("not-taken miss", mispredict, 1'b1);
    check_pc("not-taken redirect", redirect_pc, 16'h008E);
  endtask

  task automatic test_random_stream;
    pc_t  pc;
    pc_t  prev_pc;
    pc_t  tgt;
    logic en;
    logic wb;
    logic taken;
    prev_pc = '0;
    for (int n = 0; n < N_RAND; n++) begin
      en    = ($random(seed) & 7) != 0;            // Mostly active
      pc    = pc_t'($random(seed)) & 16'h003E;     // Small range, frequent aliasing
      if (n % 4 == 3) pc = prev_pc;                // Read the entry being trained
      wb    = 1'($random(seed));
      taken = 1'($random(seed));
      tgt   = pc_t'(16'h0100 + (($random(seed) & 3) << 1)); // Small target pool
      run_cycle(en, pc, wb, taken, tgt);
      prev_pc = pc;
    end
    run_cycle(1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst           = 1'b1;
    enable        = 1'b0;
    pc_curr       = '0;
    was_branch    = 1'b0;
    actual_taken  = 1'b0;
    actual_target = '0;
    reset_model();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_counter_walk();
    test_btb_training();
    test_mispredict();
    test_random_stream();

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
